//--- common/mandel_pkg.sv
package mandel_pkg;

  // command codes on the ctrl port, sampled every clock
  typedef enum logic [2:0] {
    CTRL_DEMO          = 3'b000,
    CTRL_SET_LEFT      = 3'b001,
    CTRL_SET_TOP       = 3'b010,
    CTRL_NONE          = 3'b011,
    CTRL_SET_INC_COL_X = 3'b100,
    CTRL_SET_INC_COL_Y = 3'b101,
    CTRL_SET_INC_ROW_X = 3'b110,
    CTRL_SET_INC_ROW_Y = 3'b111
  } ctrl_e;

  // a coordinate has BITS - FRAC_OFFSET fraction bits.
  // x words carry 3 integer bits and y words carry 2.
  localparam int FRAC_OFFSET = 3;

  localparam int VALUE_W   = 13; // width of the command value word.
  localparam int INC_COL_W = 10; // column increment width.
  localparam int INC_ROW_W = 8;  // row increment width.

  // the value word is read as an edge or as an increment, depending on ctrl.
  typedef union packed {
    logic [VALUE_W-1:0] coord;
    struct packed {
      logic [VALUE_W-INC_COL_W-1:0] unused;
      logic signed [INC_COL_W-1:0]  step;
    } inc;
  } cmd_value_u;

endpackage

//--- coord/coord_control.sv
`timescale 1ns/10ps

module coord_control import mandel_pkg::*; #(
  parameter int BITS = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   next_row,
  input  logic                   next_frame,
  input  cmd_value_u             value,
  input  ctrl_e                  ctrl,
  input  logic signed [BITS-1:0] x0,
  input  logic signed [BITS-2:0] y0,
  output logic signed [BITS-1:0] next_x0,
  output logic signed [BITS-2:0] next_y0
);

  localparam int FRAC = BITS - FRAC_OFFSET;

  localparam logic signed [BITS-1:0]      X_LEFT_DEFAULT    = -2 <<< FRAC;
  localparam logic signed [BITS-2:0]      Y_TOP_DEFAULT     = 3 <<< (FRAC - 2);
  localparam logic signed [INC_COL_W-1:0] X_INC_COL_DEFAULT = 240;
  localparam logic signed [INC_ROW_W-1:0] Y_INC_ROW_DEFAULT = -51;

  logic signed [BITS-1:0]      x_left;
  logic signed [BITS-2:0]      y_top;
  logic signed [INC_COL_W-1:0] x_inc_col;
  logic signed [INC_COL_W-1:0] y_inc_col;
  logic signed [INC_ROW_W-1:0] x_inc_row;
  logic signed [INC_ROW_W-1:0] y_inc_row;

  logic signed [BITS-1:0] x_row_start;
  logic signed [BITS-2:0] y_row_start;

  logic signed [BITS-1:0] edge_x;
  logic signed [BITS-2:0] edge_y;

  logic                        demo_phase;
  logic                        demo_update;
  logic                        demo_wrap;
  logic signed [BITS-2:0]      demo_y_top;
  logic signed [INC_ROW_W-1:0] demo_y_inc;
  logic signed [INC_COL_W-1:0] demo_x_inc;

  // the edge value fills the top bits of the coordinate word.
  assign edge_x = BITS'(value.coord) << (BITS - VALUE_W);
  assign edge_y = (BITS-1)'(value.coord) << (BITS - 1 - VALUE_W);

  // the zoom walks the row step from -51 up to 51 and then starts over.
  assign demo_wrap  = y_inc_row == INC_ROW_W'(51);
  assign demo_y_top = demo_wrap ? Y_TOP_DEFAULT : y0 - (BITS-1)'(240);
  assign demo_y_inc = demo_wrap ? Y_INC_ROW_DEFAULT : y_inc_row + INC_ROW_W'(1);
  assign demo_x_inc = demo_y_inc[INC_ROW_W-1] ? {~demo_y_inc, 2'b00} : {demo_y_inc, 2'b00};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      demo_phase  <= 1'b0;
      demo_update <= 1'b0;
    end else begin
      if (next_frame) begin
        demo_phase <= !demo_phase; // only every second frame zooms.
      end
      demo_update <= next_frame && ctrl == CTRL_DEMO && !demo_phase;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_left    <= X_LEFT_DEFAULT;
      y_top     <= Y_TOP_DEFAULT;
      x_inc_col <= X_INC_COL_DEFAULT;
      y_inc_col <= '0;
      x_inc_row <= '0;
      y_inc_row <= Y_INC_ROW_DEFAULT;
    end else begin
      if (ctrl == CTRL_SET_LEFT) begin
        x_left <= edge_x;
      end
      if (demo_update) begin
        y_top     <= demo_y_top;
        x_inc_col <= demo_x_inc;
        y_inc_row <= demo_y_inc;
      end else begin
        if (ctrl == CTRL_SET_TOP) begin
          y_top <= edge_y;
        end
        if (ctrl == CTRL_SET_INC_COL_X) begin
          x_inc_col <= value.inc.step;
        end
        if (ctrl == CTRL_SET_INC_ROW_Y) begin
          y_inc_row <= value.inc.step[INC_ROW_W-1:0];
        end
      end
      if (ctrl == CTRL_SET_INC_COL_Y) begin
        y_inc_col <= value.inc.step;
      end
      if (ctrl == CTRL_SET_INC_ROW_X) begin
        x_inc_row <= value.inc.step[INC_ROW_W-1:0];
      end
    end
  end

  // row starts are always loaded at the first pixel of a frame.
  always_ff @(posedge clk) begin
    if (next_frame) begin
      x_row_start <= x_left;
    end else if (next_row) begin
      x_row_start <= x_row_start + x_inc_row;
    end
  end

  always_ff @(posedge clk) begin
    if (next_frame || demo_update) begin
      y_row_start <= y_top;
    end else if (next_row) begin
      y_row_start <= y_row_start + y_inc_row;
    end
  end

  always_comb begin
    if (next_frame) begin
      next_x0 = x_left;
      next_y0 = y_top;
    end else if (next_row) begin
      next_x0 = x_row_start;
      next_y0 = y_row_start;
    end else begin
      next_x0 = x0 + x_inc_col; // step from the pixel held in the engine.
      next_y0 = y0 + y_inc_col;
    end
  end

  // the scan flags come from pixel_scan and mark distinct pixels.
  assert property (@(posedge clk) disable iff (!rst_n) !(next_frame && next_row))
    else $error("coord_control: next_frame and next_row high in the same cycle");

endmodule

//--- iterate/mandel_iter.sv
`timescale 1ns/10ps

module mandel_iter import mandel_pkg::*; #(
  parameter int BITS     = 16,
  parameter int MAX_ITER = 63
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  logic signed [BITS-1:0]          next_x0,
  input  logic signed [BITS-2:0]          next_y0,
  output logic signed [BITS-1:0]          x0,
  output logic signed [BITS-2:0]          y0,
  output logic                            done,
  output logic [$clog2(MAX_ITER+1)-1:0]   iter_count
);

  localparam int FRAC = BITS - FRAC_OFFSET;
  localparam int W    = BITS + 4; // z keeps four guard bits above the coordinate.
  localparam int CW   = $clog2(MAX_ITER + 1);

  localparam logic signed [2*W-1:0] ESC_LIMIT = 4 <<< FRAC;

  logic signed [BITS-1:0] cx;
  logic signed [BITS-2:0] cy;
  logic signed [W-1:0]    zx;
  logic signed [W-1:0]    zy;
  logic [CW-1:0]          n;
  logic                   busy;

  logic signed [2*W-1:0] xx;
  logic signed [2*W-1:0] yy;
  logic signed [2*W-1:0] xy;
  logic signed [2*W-1:0] sum_x;
  logic signed [2*W-1:0] sum_y;
  logic signed [W-1:0]   zx_next;
  logic signed [W-1:0]   zy_next;
  logic signed [2*W-1:0] nxx;
  logic signed [2*W-1:0] nyy;
  logic signed [2*W-1:0] mag;
  logic [CW-1:0]         n_next;
  logic                  escape;
  logic                  stop;

  always_comb begin
    xx = zx * zx;
    yy = zy * zy;
    xy = zx * zy;
    // products are truncated back to FRAC fraction bits.
    sum_x   = (xx >>> FRAC) - (yy >>> FRAC) + cx;
    sum_y   = (xy >>> (FRAC - 1)) + cy; // 2xy is truncated once.
    zx_next = sum_x[W-1:0];
    zy_next = sum_y[W-1:0];

    // the escape test looks at the new z, so one cycle can end the loop.
    nxx    = zx_next * zx_next;
    nyy    = zy_next * zy_next;
    mag    = (nxx >>> FRAC) + (nyy >>> FRAC);
    escape = mag > ESC_LIMIT;

    n_next = n + 1'b1;
    stop   = escape || n_next == CW'(MAX_ITER);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= busy && stop;
      if (start) begin
        busy <= 1'b1;
      end else if (busy && stop) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cx <= next_x0;
      cy <= next_y0;
      zx <= '0;
      zy <= '0;
      n  <= '0;
    end else if (busy) begin
      zx <= zx_next;
      zy <= zy_next;
      n  <= n_next;
    end
    if (busy && stop) begin
      iter_count <= n_next;
    end
  end

  // the held point is what the coordinate controller steps from.
  assign x0 = cx;
  assign y0 = cy;

  assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy) && !busy)
    else $error("mandel_iter: done without a busy cycle before it or with the engine busy");

endmodule

//--- rtl/pixel_scan.sv
`timescale 1ns/10ps

module pixel_scan #(
  parameter int COLS = 640,
  parameter int ROWS = 480
) (
  input  logic clk,
  input  logic rst_n,
  input  logic done,
  output logic start,
  output logic next_row,
  output logic next_frame,
  output logic row_first,
  output logic frame_first
);

  localparam int CW = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int RW = (ROWS > 1) ? $clog2(ROWS) : 1;

  logic [CW-1:0] col;
  logic [RW-1:0] row;
  logic          armed;
  logic          in_flight;

  // col and row point at the pixel that the next start issues.
  assign next_frame = start && col == '0 && row == '0;
  assign next_row   = start && col == '0 && row != '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed       <= 1'b0;
      start       <= 1'b0;
      in_flight   <= 1'b0;
      col         <= '0;
      row         <= '0;
      row_first   <= 1'b0;
      frame_first <= 1'b0;
    end else begin
      armed <= 1'b1;
      start <= !armed || done; // one pixel at a time.
      if (start) begin
        in_flight <= 1'b1;
      end else if (done) begin
        in_flight <= 1'b0;
      end
      if (start) begin
        row_first   <= next_row;
        frame_first <= next_frame;
        if (col == CW'(COLS - 1)) begin
          col <= '0;
          if (row == RW'(ROWS - 1)) begin
            row <= '0;
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) start |-> !in_flight)
    else $error("pixel_scan: start issued while a pixel is in flight");

endmodule

//--- rtl/mandel_top.sv
`timescale 1ns/10ps

module mandel_top import mandel_pkg::*; #(
  parameter int BITS     = 16,
  parameter int MAX_ITER = 63,
  parameter int COLS     = 640,
  parameter int ROWS     = 480
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ctrl_e                         ctrl,
  input  cmd_value_u                    value,
  output logic                          pixel_valid,
  output logic [$clog2(MAX_ITER+1)-1:0] pixel_iter,
  output logic                          pixel_row_first,
  output logic                          pixel_frame_first
);

  logic                   start;
  logic                   next_row;
  logic                   next_frame;
  logic signed [BITS-1:0] x0;
  logic signed [BITS-2:0] y0;
  logic signed [BITS-1:0] next_x0;
  logic signed [BITS-2:0] next_y0;

  pixel_scan #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) i_pixel_scan (
    .clk         (clk),
    .rst_n       (rst_n),
    .done        (pixel_valid),
    .start       (start),
    .next_row    (next_row),
    .next_frame  (next_frame),
    .row_first   (pixel_row_first),
    .frame_first (pixel_frame_first)
  );

  coord_control #(
    .BITS (BITS)
  ) i_coord_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .next_row   (next_row),
    .next_frame (next_frame),
    .value      (value),
    .ctrl       (ctrl),
    .x0         (x0),
    .y0         (y0),
    .next_x0    (next_x0),
    .next_y0    (next_y0)
  );

  mandel_iter #(
    .BITS     (BITS),
    .MAX_ITER (MAX_ITER)
  ) i_mandel_iter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .next_x0    (next_x0),
    .next_y0    (next_y0),
    .x0         (x0),
    .y0         (y0),
    .done       (pixel_valid),
    .iter_count (pixel_iter)
  );

endmodule

//--- verification/mandel_tb.sv
`timescale 1ns/10ps

module mandel_tb import mandel_pkg::*; ();

  localparam int BITS       = 16;
  localparam int MAX_ITER   = 31;
  localparam int COLS       = 8;
  localparam int ROWS       = 6;
  localparam int FRAC       = BITS - FRAC_OFFSET;
  localparam int W          = BITS + 4;
  localparam int CW         = $clog2(MAX_ITER + 1);
  localparam int NUM_FRAMES = 18;
  localparam longint WATCHDOG_NS =
    longint'(NUM_FRAMES) * COLS * ROWS * (MAX_ITER + 3) * 10 + 1000;

  logic          clk;
  logic          rst_n;
  ctrl_e         ctrl;
  cmd_value_u    value;
  logic          pixel_valid;
  logic [CW-1:0] pixel_iter;
  logic          pixel_row_first;
  logic          pixel_frame_first;

  int   errors;
  int   pixels_checked;
  int   max_hits;
  int   small_hits;
  event last_pixel_started;
  event frame_done;

  // reference copy of the coordinate registers.
  logic signed [BITS-1:0]      m_x_left;
  logic signed [BITS-2:0]      m_y_top;
  logic signed [INC_COL_W-1:0] m_inc_col_x;
  logic signed [INC_COL_W-1:0] m_inc_col_y;
  logic signed [INC_ROW_W-1:0] m_inc_row_x;
  logic signed [INC_ROW_W-1:0] m_inc_row_y;
  logic signed [BITS-1:0]      m_xrs;
  logic signed [BITS-2:0]      m_yrs;
  logic signed [BITS-1:0]      m_cx;
  logic signed [BITS-2:0]      m_cy;
  logic                        m_phase;
  logic                        m_demo_due;
  int                          m_col;
  int                          m_row;
  int                          cyc;
  int                          start_at;
  int                          done_at;
  int                          exp_count;
  logic                        exp_row_first;
  logic                        exp_frame_first;

  always #5 clk = ~clk;

  mandel_top #(
    .BITS     (BITS),
    .MAX_ITER (MAX_ITER),
    .COLS     (COLS),
    .ROWS     (ROWS)
  ) i_mandel_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .ctrl              (ctrl),
    .value             (value),
    .pixel_valid       (pixel_valid),
    .pixel_iter        (pixel_iter),
    .pixel_row_first   (pixel_row_first),
    .pixel_frame_first (pixel_frame_first)
  );

  // escape-time count for one point with z kept in W bits and truncating products.
  function automatic int ref_count(input longint cx, input longint cy);
    logic signed [W-1:0] zx;
    logic signed [W-1:0] zy;
    logic signed [W-1:0] tx;
    longint              mag;
    int                  n;
    zx = '0;
    zy = '0;
    n  = 0;
    do begin
      tx  = ((longint'(zx) * zx) >>> FRAC) - ((longint'(zy) * zy) >>> FRAC) + cx;
      zy  = ((longint'(zx) * zy) >>> (FRAC - 1)) + cy;
      zx  = tx;
      mag = ((longint'(zx) * zx) >>> FRAC) + ((longint'(zy) * zy) >>> FRAC);
      n++;
    end while (mag <= (longint'(4) <<< FRAC) && n < MAX_ITER);
    return n;
  endfunction

  function automatic cmd_value_u edge_word(input int fixed_val, input int shift);
    cmd_value_u w;
    w.coord = fixed_val >>> shift; // top bits of the coordinate word.
    return w;
  endfunction

  function automatic cmd_value_u inc_word(input int step);
    cmd_value_u w;
    w.inc.unused = '0;
    w.inc.step   = step[INC_COL_W-1:0];
    return w;
  endfunction

  task automatic check_value(input string what, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // two command words in the gap after the last pixel of a frame has started.
  task automatic command_gap(input ctrl_e c1, input cmd_value_u v1, input ctrl_e c2,
                             input cmd_value_u v2, input ctrl_e hold);
    @(last_pixel_started);
    ctrl  <= c1;
    value <= v1;
    @(posedge clk);
    ctrl  <= c2;
    value <= v2;
    @(posedge clk);
    ctrl  <= hold;
  endtask

  task automatic skip_frames(input int n);
    repeat (n) @(last_pixel_started);
  endtask

  always @(posedge clk) begin
    logic signed [BITS-1:0]      px;
    logic signed [BITS-2:0]      py;
    logic signed [INC_ROW_W-1:0] d;
    logic                        demo_now;
    logic                        frame_px;
    logic                        row_px;
    if (!rst_n) begin
      m_x_left    = -(2 <<< FRAC);
      m_y_top     = 3 <<< (FRAC - 2);
      m_inc_col_x = 240;
      m_inc_col_y = 0;
      m_inc_row_x = 0;
      m_inc_row_y = -51;
      m_phase     = 1'b0;
      m_demo_due  = 1'b0;
      m_col       = 0;
      m_row       = 0;
      cyc         = 0;
      start_at    = 1; // first start one cycle after reset is released.
      done_at     = -1;
    end else begin
      demo_now   = m_demo_due;
      m_demo_due = 1'b0;
      check_value("pixel_valid", pixel_valid, cyc == done_at);
      if (cyc == done_at) begin
        check_value("pixel_iter", pixel_iter, exp_count);
        check_value("pixel_row_first", pixel_row_first, exp_row_first);
        check_value("pixel_frame_first", pixel_frame_first, exp_frame_first);
        pixels_checked++;
        max_hits   += (exp_count == MAX_ITER);
        small_hits += (exp_count <= 2);
        start_at = cyc + 1;
        if (m_col == 0 && m_row == 0) begin
          -> frame_done;
        end
      end
      if (cyc == start_at) begin
        frame_px = m_col == 0 && m_row == 0;
        row_px   = m_col == 0 && m_row != 0;
        if (frame_px) begin
          px    = m_x_left;
          py    = m_y_top;
          m_xrs = m_x_left;
          m_yrs = m_y_top;
          m_demo_due = ctrl == CTRL_DEMO && !m_phase;
          m_phase    = !m_phase;
        end else if (row_px) begin
          px    = m_xrs; // a row begins at the current row start, which then steps.
          py    = m_yrs;
          m_xrs = m_xrs + m_inc_row_x;
          m_yrs = m_yrs + m_inc_row_y;
        end else begin
          px = m_cx + m_inc_col_x;
          py = m_cy + m_inc_col_y;
        end
        exp_count       = ref_count(px, py);
        exp_row_first   = row_px;
        exp_frame_first = frame_px;
        done_at = cyc + exp_count + 1;
        m_cx    = px;
        m_cy    = py;
        if (m_col == COLS - 1 && m_row == ROWS - 1) begin
          -> last_pixel_started;
        end
        if (m_col == COLS - 1) begin
          m_col = 0;
          m_row = (m_row == ROWS - 1) ? 0 : m_row + 1;
        end else begin
          m_col++;
        end
      end
      case (ctrl)
        CTRL_SET_LEFT:      m_x_left    = {value.coord, 3'b000};
        CTRL_SET_TOP:       m_y_top     = {value.coord, 2'b00};
        CTRL_SET_INC_COL_X: m_inc_col_x = value.inc.step;
        CTRL_SET_INC_COL_Y: m_inc_col_y = value.inc.step;
        CTRL_SET_INC_ROW_X: m_inc_row_x = value.inc.step[INC_ROW_W-1:0];
        CTRL_SET_INC_ROW_Y: m_inc_row_y = value.inc.step[INC_ROW_W-1:0];
        default: ;
      endcase
      if (demo_now) begin
        d = (m_inc_row_y == 51) ? -51 : m_inc_row_y + 1;
        m_yrs       = m_y_top;
        m_y_top     = (m_inc_row_y == 51) ? 3 <<< (FRAC - 2) : m_cy - 240;
        m_inc_row_y = d;
        m_inc_col_x = (d < 0) ? (-d - 1) * 4 : d * 4;
      end
      cyc++;
    end
  end

  initial begin
    int col_y;
    int row_x;
    int row_y;
    clk   = 1'b0;
    rst_n = 1'b0;
    ctrl  = CTRL_NONE;
    value = '0;
    void'($urandom(32'h8d5e));
    col_y = int'($urandom % 40) - 20;
    row_x = int'($urandom % 64) - 32;
    row_y = -10 - int'($urandom % 80);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // frame 0 is the default view and frame 1 moves to -0.5 + 0.25i inside the set.
    command_gap(CTRL_SET_LEFT, edge_word(-4096, 3), CTRL_SET_TOP, edge_word(2048, 2),
                CTRL_NONE);
    command_gap(CTRL_SET_INC_COL_X, inc_word(400), CTRL_SET_INC_COL_Y, inc_word(col_y),
                CTRL_NONE);
    command_gap(CTRL_SET_INC_ROW_X, inc_word(row_x), CTRL_SET_INC_ROW_Y, inc_word(row_y),
                CTRL_NONE);
    // from 48 the zoom reaches 51 on its third update and wraps on the fourth.
    command_gap(CTRL_SET_INC_ROW_Y, inc_word(48), CTRL_DEMO, '0, CTRL_DEMO);
    skip_frames(9);
    command_gap(CTRL_NONE, '0, CTRL_NONE, '0, CTRL_NONE);
    skip_frames(1);
    @(frame_done);
    check_value("pixels checked", pixels_checked, 15 * COLS * ROWS);
    check_value("pixels at MAX_ITER seen", max_hits > 0, 1);
    check_value("pixels with a small count seen", small_hits > 0, 1);
    $display("mandel_tb: %0d errors over %0d pixels", errors, pixels_checked);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d pixels, the run did not finish", pixels_checked);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- src.f
common/mandel_pkg.sv
coord/coord_control.sv
iterate/mandel_iter.sv
rtl/pixel_scan.sv
rtl/mandel_top.sv
verification/mandel_tb.sv

//--- Bender.yml
package:
  name: mandel

sources:
  - common/mandel_pkg.sv
  - coord/coord_control.sv
  - iterate/mandel_iter.sv
  - rtl/pixel_scan.sv
  - rtl/mandel_top.sv
  - target: simulation
    files:
      - verification/mandel_tb.sv
